/* verilog/fetch_macros.svh */
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// program counter width in bits
`define ADDR_WIDTH 32

// one rv32 instruction word
`define INSTR_WIDTH 32

// instruction memory size in words
// indexed by pc[9:2], so fetch addresses wrap every 1 KB
`define IMEM_WORDS 256

// fetch queue entries between fetch and decode
`define FQ_DEPTH 4

// pc value after reset
`define RESET_PC 32'h0000_0000

`endif

/* verilog/fetch_pkg.sv */
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

    // basic datapath words
    typedef logic [`ADDR_WIDTH-1:0]  addr_t;
    typedef logic [`INSTR_WIDTH-1:0] instr_t;

    // one fetched instruction on its way to decode
    // 32 + 32 + 1 + 1 + 32 = 98 bits
    typedef struct packed {
        addr_t  pc;
        instr_t instr;
        logic   is_cond_branch;
        logic   pred_taken;
        addr_t  pred_npc;
    } fetch_entry_t;

    // major opcodes in instr[6:0]
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

endpackage

`default_nettype wire

/* verilog/predicted_npc.sv */
`timescale 1ns/1ps
`default_nettype none

module predicted_npc (
    input  fetch_pkg::instr_t instr,
    input  fetch_pkg::addr_t  pc,
    output logic              is_cond_branch,
    output logic              br_prediction,
    output fetch_pkg::addr_t  next_pc
);

    logic [6:0]       opcode;
    logic             is_branch;
    logic             is_jal;
    logic             is_jalr;
    logic             is_backward;
    fetch_pkg::addr_t b_imm;
    fetch_pkg::addr_t j_imm;
    fetch_pkg::addr_t pc_plus4;
    fetch_pkg::addr_t br_target;
    fetch_pkg::addr_t jal_target;

    // opcode classes
    assign opcode    = instr[6:0];
    assign is_branch = (opcode == fetch_pkg::OPC_BRANCH);
    assign is_jal    = (opcode == fetch_pkg::OPC_JAL);
    assign is_jalr   = (opcode == fetch_pkg::OPC_JALR);

    // sign bit of the b-immediate doubles as the direction bit
    assign is_backward = instr[31];

    // 13-bit b-type offset with lsb zero
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // 21-bit j-type offset with lsb zero
    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // three candidate targets computed in parallel
    assign pc_plus4   = pc + fetch_pkg::addr_t'(4);
    assign br_target  = pc + b_imm;
    assign jal_target = pc + j_imm;

    // only b-type words are conditional
    assign is_cond_branch = is_branch;

    // backward-taken, forward-not-taken; jal always taken
    assign br_prediction = is_jal | (is_branch & is_backward);

    always_comb begin
        if (is_jalr) begin
            // register target unknown at fetch
            // fall through and let resolution redirect
            next_pc = pc_plus4;
        end else if (is_jal) begin
            next_pc = jal_target;
        end else if (is_branch && is_backward) begin
            // likely a loop back edge
            next_pc = br_target;
        end else begin
            // forward branch or plain word
            next_pc = pc_plus4;
        end
    end

endmodule

`default_nettype wire

/* verilog/imem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module imem (
    input  wire               clk,
    input  logic              load_en,
    input  logic [7:0]        load_addr,
    input  fetch_pkg::instr_t load_data,
    input  fetch_pkg::addr_t  pc,
    output fetch_pkg::instr_t instr
);

    // word array with contents undefined until loaded
    fetch_pkg::instr_t mem [`IMEM_WORDS];

    logic [7:0] rd_idx;

    // word index from the byte pc
    // upper bits ignored so addresses wrap at 1 KB
    assign rd_idx = pc[9:2];

    // load port writes one word per edge
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // combinational read within the fetch cycle
    assign instr = mem[rd_idx];

endmodule

`default_nettype wire

/* verilog/fetch_pc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_pc (
    input  wire                     clk,
    input  wire                     rst_n,
    input  logic                    fetch_en,
    input  logic                    full,
    input  logic                    redirect,
    input  fetch_pkg::addr_t        redirect_pc,
    input  fetch_pkg::instr_t       instr,
    output fetch_pkg::addr_t        pc,
    output logic                    push,
    output fetch_pkg::fetch_entry_t entry
);

    logic             is_cond_branch;
    logic             pred_taken;
    fetch_pkg::addr_t pred_npc;
    fetch_pkg::addr_t pc_next;

    // static prediction on the word read this cycle
    predicted_npc u_predicted_npc (
        .instr          (instr),
        .pc             (pc),
        .is_cond_branch (is_cond_branch),
        .br_prediction  (pred_taken),
        .next_pc        (pred_npc)
    );

    // one push per cycle unless the queue is full
    // a redirect cancels the word fetched this cycle
    assign push = fetch_en & ~full & ~redirect;

    // entry handed to the queue
    assign entry.pc             = pc;
    assign entry.instr          = instr;
    assign entry.is_cond_branch = is_cond_branch;
    assign entry.pred_taken     = pred_taken;
    assign entry.pred_npc       = pred_npc;

    // redirect first, then follow the prediction, else hold
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (push) begin
            pc_next = pred_npc;
        end else begin
            pc_next = pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_queue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_queue #(
    parameter type entry_t = fetch_pkg::fetch_entry_t,
    parameter int  DEPTH   = `FQ_DEPTH
) (
    input  wire    clk,
    input  wire    rst_n,
    input  logic   flush,
    input  logic   push,
    input  entry_t push_data,
    input  logic   pop,
    output entry_t head,
    output logic   valid,
    output logic   full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // payload storage
    entry_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;
    logic             do_push;

    // status from the count at the start of the cycle
    assign valid = (count != '0);
    assign full  = (count == CNT_W'(DEPTH));

    // pop on empty is dropped
    assign do_pop  = pop & valid;
    // a pop in the same cycle frees the slot for the push
    assign do_push = push & (~full | do_pop);

    // oldest entry is visible right after the edge that wrote it
    assign head = mem[rd_ptr];

    // circular write side
    always_ff @(posedge clk) begin
        if (do_push && !flush) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers and count; flush beats push and pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leave count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  wire               clk,
    input  wire               rst_n,
    input  logic              fetch_en,
    input  logic              redirect,
    input  fetch_pkg::addr_t  redirect_pc,
    input  logic              load_en,
    input  logic [7:0]        load_addr,
    input  fetch_pkg::instr_t load_data,
    input  logic              deq_pop,
    output logic              deq_valid,
    output fetch_pkg::addr_t  deq_pc,
    output fetch_pkg::instr_t deq_instr,
    output logic              deq_is_cond_branch,
    output logic              deq_pred_taken,
    output fetch_pkg::addr_t  deq_pred_npc
);

    fetch_pkg::addr_t        pc;
    fetch_pkg::instr_t       instr;
    logic                    push;
    logic                    full;
    fetch_pkg::fetch_entry_t entry;
    fetch_pkg::fetch_entry_t head;

    // instruction store, read at the current pc
    imem u_imem (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .pc        (pc),
        .instr     (instr)
    );

    // pc register and prediction
    fetch_pc u_fetch_pc (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_en    (fetch_en),
        .full        (full),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr       (instr),
        .pc          (pc),
        .push        (push),
        .entry       (entry)
    );

    // decoupling queue emptied on redirect
    fetch_queue #(
        .entry_t (fetch_pkg::fetch_entry_t)
    ) u_fetch_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (redirect),
        .push      (push),
        .push_data (entry),
        .pop       (deq_pop),
        .head      (head),
        .valid     (deq_valid),
        .full      (full)
    );

    // head entry out as separate fields
    assign deq_pc             = head.pc;
    assign deq_instr          = head.instr;
    assign deq_is_cond_branch = head.is_cond_branch;
    assign deq_pred_taken     = head.pred_taken;
    assign deq_pred_npc       = head.pred_npc;

endmodule

`default_nettype wire

/* tests/fetch_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_assertions #(
    parameter int DEPTH = `FQ_DEPTH,
    parameter int CNT_W = $clog2(DEPTH + 1)
) (
    input logic             clk,
    input logic             rst_n,
    input logic             flush,
    input logic             push,
    input logic             valid,
    input logic             full,
    input logic [CNT_W-1:0] count
);

    // running count of assertion failures
    int fail_count = 0;

    // occupancy never runs past the queue depth
    count_within_depth: assert property (@(posedge clk) disable iff (!rst_n)
        count <= CNT_W'(DEPTH))
    else begin
        fail_count++;
        $error("queue count %0d exceeds depth %0d", count, DEPTH);
    end

    // fetch side never pushes into a full queue
    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(push && full))
    else begin
        fail_count++;
        $error("push asserted while the queue is full");
    end

    // flush empties the queue in one edge
    empty_after_flush: assert property (@(posedge clk) disable iff (!rst_n)
        $past(flush) |-> !valid)
    else begin
        fail_count++;
        $error("queue still valid the cycle after a flush");
    end

endmodule

// attach to every fetch queue instance
bind fetch_queue fetch_assertions #(.DEPTH(DEPTH)) u_queue_checks (
    .clk   (clk),
    .rst_n (rst_n),
    .flush (flush),
    .push  (push),
    .valid (valid),
    .full  (full),
    .count (count)
);

`default_nettype wire

/* tests/fetch_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_clock #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    // free-running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset low for a few edges and released between edges
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tests/fetch_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_checker (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              fetch_en,
    input  logic              redirect,
    input  fetch_pkg::addr_t  redirect_pc,
    input  logic              deq_pop,
    input  logic              deq_valid,
    input  fetch_pkg::addr_t  deq_pc,
    input  fetch_pkg::instr_t deq_instr,
    input  logic              deq_is_cond_branch,
    input  logic              deq_pred_taken,
    input  fetch_pkg::addr_t  deq_pred_npc,
    input  fetch_pkg::instr_t model_mem [`IMEM_WORDS],
    input  logic [1:0]        model_kind [`IMEM_WORDS],
    input  fetch_pkg::addr_t  model_off [`IMEM_WORDS],
    output int                error_count,
    output int                checked_count
);

    // word classes as the generator writes them
    localparam logic [1:0] KIND_BRANCH = 2'd1;
    localparam logic [1:0] KIND_JAL    = 2'd2;

    // pc the next dequeued entry must carry
    fetch_pkg::addr_t exp_pc;
    logic             prev_fetch;
    logic             prev_redirect;
    logic             prev_valid;
    logic             prev_pop;
    logic             seen_fetch;

    initial begin
        error_count   = 0;
        checked_count = 0;
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, actual %h at %0t", name, expected, actual, $time);
            error_count++;
        end
    endtask

    task automatic problem(input string what);
        $display("ERROR at %0t: %s", $time, what);
        error_count++;
    endtask

    // one popped entry against the memory model and the btfn rule
    task automatic check_entry();
        logic [7:0]       idx;
        logic [1:0]       kind;
        logic             taken;
        fetch_pkg::addr_t npc;
        idx   = deq_pc[9:2];
        kind  = model_kind[idx];
        // jal always taken and a conditional branch only when its offset points back
        taken = (kind == KIND_JAL) || (kind == KIND_BRANCH && model_off[idx][31]);
        npc   = taken ? deq_pc + model_off[idx] : deq_pc + 32'd4;
        compare("pc sequence", exp_pc, deq_pc);
        compare("instruction word", model_mem[idx], deq_instr);
        compare("is_cond_branch", {31'd0, kind == KIND_BRANCH}, {31'd0, deq_is_cond_branch});
        compare("pred_taken", {31'd0, taken}, {31'd0, deq_pred_taken});
        compare("pred_npc", npc, deq_pred_npc);
        // resync on the model so one slip reports once
        exp_pc = npc;
        checked_count++;
    endtask

    // values read here are the ones before the edge
    always @(posedge clk) begin
        if (!rst_n) begin
            exp_pc        = `RESET_PC;
            prev_fetch    = 1'b0;
            prev_redirect = 1'b0;
            prev_valid    = 1'b0;
            prev_pop      = 1'b0;
            seen_fetch    = 1'b0;
        end else begin
            if (!seen_fetch && deq_valid) begin
                problem("deq_valid high before any fetch cycle");
            end
            // a fetch cycle either pushed or found the queue full
            if (prev_fetch && !prev_redirect && !deq_valid) begin
                problem("no entry visible one cycle after a fetch cycle");
            end
            // entries stay put under back-pressure
            if (prev_valid && !prev_pop && !prev_redirect && !deq_valid) begin
                problem("deq_valid dropped without a pop or redirect");
            end
            // redirect flushes and the pop is dropped
            if (redirect) begin
                exp_pc = redirect_pc;
            end else if (deq_pop && deq_valid) begin
                check_entry();
            end
            prev_fetch    = fetch_en;
            prev_redirect = redirect;
            prev_valid    = deq_valid;
            prev_pop      = deq_pop;
            if (fetch_en) begin
                seen_fetch = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb;

    localparam int          CLK_NS      = 4;
    localparam int          RUN_CYCLES  = 3000;
    localparam int          WATCHDOG_NS = (RUN_CYCLES + 300) * CLK_NS;
    localparam logic [31:0] SEED        = 32'd68409;

    // word classes shared with the checker
    localparam logic [1:0] KIND_ALU    = 2'd0;
    localparam logic [1:0] KIND_BRANCH = 2'd1;
    localparam logic [1:0] KIND_JAL    = 2'd2;
    localparam logic [1:0] KIND_JALR   = 2'd3;

    logic              clk, rst_n;
    logic              fetch_en, redirect, load_en, deq_pop;
    fetch_pkg::addr_t  redirect_pc;
    logic [7:0]        load_addr;
    fetch_pkg::instr_t load_data;
    logic              deq_valid, deq_is_cond_branch, deq_pred_taken;
    fetch_pkg::addr_t  deq_pc, deq_pred_npc;
    fetch_pkg::instr_t deq_instr;

    // memory image model with each word's class and byte offset
    fetch_pkg::instr_t model_mem [`IMEM_WORDS];
    logic [1:0]        model_kind [`IMEM_WORDS];
    fetch_pkg::addr_t  model_off [`IMEM_WORDS];

    logic [31:0] rng_state;
    int          error_count, checked_count, assert_fails;

    fetch_clock #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(5)) u_clock (.clk(clk), .rst_n(rst_n));

    fetch_unit uut (
        .clk(clk), .rst_n(rst_n), .fetch_en(fetch_en), .redirect(redirect),
        .redirect_pc(redirect_pc), .load_en(load_en), .load_addr(load_addr),
        .load_data(load_data), .deq_pop(deq_pop), .deq_valid(deq_valid), .deq_pc(deq_pc),
        .deq_instr(deq_instr), .deq_is_cond_branch(deq_is_cond_branch),
        .deq_pred_taken(deq_pred_taken), .deq_pred_npc(deq_pred_npc)
    );

    fetch_checker u_checker (
        .clk(clk), .rst_n(rst_n), .fetch_en(fetch_en), .redirect(redirect),
        .redirect_pc(redirect_pc), .deq_pop(deq_pop), .deq_valid(deq_valid), .deq_pc(deq_pc),
        .deq_instr(deq_instr), .deq_is_cond_branch(deq_is_cond_branch),
        .deq_pred_taken(deq_pred_taken), .deq_pred_npc(deq_pred_npc),
        .model_mem(model_mem), .model_kind(model_kind), .model_off(model_off),
        .error_count(error_count), .checked_count(checked_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // random branch, jal, jalr or alu word with offsets of 1 to 8 words either way
    task automatic make_word(input logic [31:0] r, output fetch_pkg::instr_t w,
                             output logic [1:0] kind, output fetch_pkg::addr_t off);
        fetch_pkg::addr_t mag;
        mag = (32'(r[6:4]) + 32'd1) << 2;
        off = r[7] ? (32'd0 - mag) : mag;
        if (r[11:8] < 4'd5) begin
            kind = KIND_BRANCH;
            w = {off[12], off[10:5], r[24:20], r[19:15], r[14:12], off[4:1], off[11],
                 fetch_pkg::OPC_BRANCH};
        end else if (r[11:8] < 4'd7) begin
            kind = KIND_JAL;
            w = {off[20], off[10:1], off[11], off[19:12], r[16:12], fetch_pkg::OPC_JAL};
        end else if (r[11:8] == 4'd7) begin
            kind = KIND_JALR;
            off  = 32'd0;
            w    = {r[31:20], r[19:15], 3'b000, r[28:24], fetch_pkg::OPC_JALR};
        end else begin
            kind = KIND_ALU;
            off  = 32'd0;
            w    = {r[31:7], r[12] ? 7'b0110011 : 7'b0010011};
        end
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog: run still going after %0d ns, stopping", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin : stimulus
        fetch_pkg::instr_t w;
        logic [1:0]        kind;
        fetch_pkg::addr_t  off;
        logic [31:0]       r;
        fetch_en    = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        deq_pop     = 1'b0;
        rng_state   = SEED;
        // image load overlaps reset while fetch stays off
        for (int i = 0; i < `IMEM_WORDS; i++) begin
            @(negedge clk);
            rng_state = xorshift32(rng_state);
            make_word(rng_state, w, kind, off);
            model_mem[i]  = w;
            model_kind[i] = kind;
            model_off[i]  = off;
            load_en       = 1'b1;
            load_addr     = 8'(i);
            load_data     = w;
        end
        @(negedge clk);
        load_en = 1'b0;
        for (int cyc = 0; cyc < RUN_CYCLES; cyc++) begin
            @(negedge clk);
            rng_state = xorshift32(rng_state);
            r         = rng_state;
            fetch_en  = (r[3:0] != 4'd0);
            // 40 pop-free cycles out of every 250 let the queue fill
            deq_pop   = ((cyc % 250) < 210) && (r[6:4] < 3'd5);
            redirect  = (r[12:7] == 6'd0);
            rng_state = xorshift32(rng_state);
            redirect_pc = {rng_state[31:2], 2'b00};
        end
        @(negedge clk);
        fetch_en = 1'b0;
        deq_pop  = 1'b0;
        redirect = 1'b0;
        @(negedge clk);
        assert_fails = uut.u_fetch_queue.u_queue_checks.fail_count;
        $display("checker errors: %0d, assertion failures: %0d, entries checked: %0d",
                 error_count, assert_fails, checked_count);
        if (error_count == 0 && assert_fails == 0 && checked_count >= 100) begin
            $display("Simulation PASSED");
        end else begin
            if (checked_count < 100) begin
                $display("too few entries were dequeued to judge the run");
            end
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+verilog
verilog/fetch_pkg.sv
verilog/predicted_npc.sv
verilog/imem.sv
verilog/fetch_pc.sv
verilog/fetch_queue.sv
verilog/fetch_unit.sv
tests/fetch_assertions.sv
tests/fetch_clock.sv
tests/fetch_checker.sv
tests/fetch_tb.sv

/* Makefile */
# verilator flow for the fetch unit testbench

LOG = run.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module fetch_tb -f all.f

# the error limit lets every assertion failure reach the final report
run: compile
	./obj_dir/Vfetch_tb +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
